// File: build.f
design/conv_cfg_pkg.sv
design/conv_types_pkg.sv
design/operand_buffer.sv
design/pe_array.sv
design/opsum_buffer.sv
design/conv_ctrl.sv
design/conv_unit.sv
tests/tb_conv_unit.sv

// File: Bender.yml
package:
  name: conv_unit

sources:
  - design/conv_cfg_pkg.sv
  - design/conv_types_pkg.sv
  - design/operand_buffer.sv
  - design/pe_array.sv
  - design/opsum_buffer.sv
  - design/conv_ctrl.sv
  - design/conv_unit.sv
  - target: simulation
    files:
      - tests/tb_conv_unit.sv

// File: tests/tb_conv_unit.sv
`timescale 1ns/100ps

module tb_conv_unit;
    import conv_cfg_pkg::*;

    localparam int TIMEOUT = 200;                     // cycles allowed per wait loop

    typedef struct packed {
        logic [ROW_EN_W-1:0]              row_en;
        logic                             load_w;     // new weights this pass
        logic [ROWS-1:0][BUS_W-1:0]       weights;    // word r is weight row r
        logic [BUS_W-1:0]                 ifmap;
        logic [PSUM_WORDS-1:0][BUS_W-1:0] ipsum;
        logic                             stall;      // random valid / ready_op drops
    } pass_t;

    logic                       clk, reset;
    logic [BUS_W-1:0]           data_in, data_out;
    logic                       valid_w, valid_if, valid_ip, valid_op;
    logic                       ready_w, ready_if, ready_ip, ready_op;
    logic [ROW_EN_W-1:0]        row_en;
    pass_t                      pass_q [$];           // stimulus table
    logic [ROWS-1:0][BUS_W-1:0] model_w;              // weights the DUT should hold
    logic [31:0]                rng;
    int                         err_count, tests_ok, tests_bad;
    logic                       timed_out;

    conv_unit conv_unit_inst (
        .clk(clk), .reset(reset), .data_in(data_in), .data_out(data_out),
        .valid_w(valid_w), .valid_if(valid_if), .valid_ip(valid_ip),
        .ready_w(ready_w), .ready_if(ready_if), .ready_ip(ready_ip),
        .valid_op(valid_op), .ready_op(ready_op), .row_en(row_en)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;                       // 40 ns period
    end

    //----------------------------------------------------------------------
    // helpers
    //----------------------------------------------------------------------
    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s ^ (s << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic logic rand_bit();
        rng = xorshift32(rng);
        return rng[9];
    endfunction

    // opsum[r] = ipsum[r] + sum_c w[r][c] * ifmap[c], wrapped to 16 bits
    function automatic logic [PSUM_WORDS-1:0][BUS_W-1:0] expected_opsum(
        input logic [ROWS-1:0][BUS_W-1:0] w, input logic [BUS_W-1:0] ifm,
        input logic [PSUM_WORDS-1:0][BUS_W-1:0] ip, input int rows);
        logic [PSUM_WORDS-1:0][BUS_W-1:0] res;
        int acc;
        res = '0;
        for (int r = 0; r < rows; r++) begin
            acc = $signed(ip[r/2][16*(r%2) +: 16]);  // row 2k low, 2k+1 high
            for (int c = 0; c < COLS; c++) begin
                acc = acc + $signed(w[r][8*c +: 8]) * $signed(ifm[8*c +: 8]);
            end
            res[r/2][16*(r%2) +: 16] = acc[15:0];
        end
        return res;
    endfunction

    task automatic add_pass(input int re, input logic lw, input logic [31:0] w0, w1, w2, w3,
                            input logic [31:0] ifm, ip0, ip1, input logic st);
        pass_q.push_back({3'(re), lw, {w3, w2, w1, w0}, ifm, {ip1, ip0}, st});
    endtask

    task automatic check_idle(input string where);
        assert (!ready_w && !ready_if && !ready_ip && !valid_op && data_out == '0)
        else begin
            $display("FAIL at %0t: %s, handshake outputs or data_out not idle", $time, where);
            err_count++;
        end
    endtask

    task automatic report_test(input int idx, input int errs_before);
        if (err_count == errs_before) begin
            tests_ok++;
            $display("test %0d: ok", idx);
        end else begin
            tests_bad++;
            $display("test %0d: %0d errors", idx, err_count - errs_before);
        end
    endtask

    //----------------------------------------------------------------------
    // bus drivers acting 2 ns after the rising edge
    //----------------------------------------------------------------------
    task automatic send_word(input int ch, input logic [BUS_W-1:0] word, input logic stall);
        int   waited;
        logic v;
        logic rdy;
        logic done;
        waited = 0;
        done = 1'b0;
        while (!done && !timed_out) begin
            @(posedge clk);
            #2;
            v = stall ? rand_bit() : 1'b1;
            data_in  = word;
            valid_w  = (ch == 0) && v;                // 0 weights, 1 ifmap, 2 ipsum
            valid_if = (ch == 1) && v;
            valid_ip = (ch == 2) && v;
            ready_op = 1'b0;
            rdy = (ch == 0) ? ready_w : ((ch == 1) ? ready_if : ready_ip);
            assert (data_out == '0 && $countones({ready_w, ready_if, ready_ip, valid_op}) <= 1)
            else begin
                $display("FAIL at %0t: outputs wrong during load, data_out %h", $time, data_out);
                err_count++;
            end
            if (v && rdy) begin
                done = 1'b1;                          // transfers on the next edge
            end else begin
                waited++;
                if (waited > TIMEOUT) begin
                    $display("timeout: a load word on channel %0d was never accepted", ch);
                    timed_out = 1'b1;
                    err_count++;
                end
            end
        end
    endtask

    task automatic receive_words(input int n, input logic [PSUM_WORDS-1:0][BUS_W-1:0] exp,
                                 input logic stall, input int idx);
        int got;
        int waited;
        got = 0;
        waited = 0;
        while (got < n && !timed_out) begin
            @(posedge clk);
            #2;
            valid_w  = 1'b0;
            valid_if = 1'b0;
            valid_ip = 1'b0;
            ready_op = stall ? rand_bit() : 1'b1;
            if (valid_op) begin                       // word must hold while stalled
                assert (data_out == exp[got])
                else begin
                    $display("FAIL at %0t: test %0d opsum word %0d is %h, expected %h",
                             $time, idx, got, data_out, exp[got]);
                    err_count++;
                end
                if (ready_op) begin
                    got++;
                end
            end else begin
                assert (data_out == '0)
                else begin
                    $display("FAIL at %0t: test %0d data_out is %h while valid_op is low",
                             $time, idx, data_out);
                    err_count++;
                end
            end
            if (got < n) begin
                waited++;
                if (waited > TIMEOUT) begin
                    $display("timeout: test %0d got only %0d of %0d opsum words",
                             idx, got, n);
                    timed_out = 1'b1;
                    err_count++;
                end
            end
        end
        if (!timed_out) begin                         // back in IDLE with no extra word
            @(posedge clk);
            #2;
            ready_op = 1'b0;
            check_idle("after opsum phase");
        end
    endtask

    task automatic run_pass(input pass_t p, input int idx);
        logic [PSUM_WORDS-1:0][BUS_W-1:0] exp;
        int n_psum;
        n_psum = (p.row_en + 1) / PSUM_PER_WORD;
        row_en = p.row_en;                            // stable until IDLE again
        if (p.load_w) begin
            for (int r = 0; r < p.row_en; r++) begin
                model_w[r] = p.weights[r];
            end
        end
        exp = expected_opsum(model_w, p.ifmap, p.ipsum, p.row_en);
        if (p.load_w) begin
            for (int r = 0; r < p.row_en; r++) begin
                send_word(0, p.weights[r], p.stall);
            end
        end
        send_word(1, p.ifmap, p.stall);
        for (int k = 0; k < n_psum; k++) begin
            send_word(2, p.ipsum[k], p.stall);
        end
        receive_words(n_psum, exp, p.stall, idx);
    endtask

    //----------------------------------------------------------------------
    // main sequence
    //----------------------------------------------------------------------
    initial begin
        int errs_before;
        reset = 1'b1;
        data_in = '0;
        valid_w = 1'b0;
        valid_if = 1'b0;
        valid_ip = 1'b0;
        ready_op = 1'b0;
        row_en = ROW_EN_W'(ROWS);
        rng = 32'd87;
        err_count = 0;
        tests_ok = 0;
        tests_bad = 0;
        timed_out = 1'b0;
        model_w = '0;
        add_pass(4, 1, 32'h04030201, 32'hFEFF0102, 32'h10F00810, 32'h7F80017F,
                 32'h05FB0302, 32'hFF9C0064, 32'h00101234, 0);
        add_pass(4, 0, 32'h0, 32'h0, 32'h0, 32'h0,                   // reuses weights
                 32'hFE0407F9, 32'h00020001, 32'h000FFFF0, 0);
        add_pass(1, 1, 32'h0A0B0C0D, 32'h11111111, 32'h22222222, 32'h33333333,
                 32'h01010101, 32'h01005555, 32'h0, 0);
        add_pass(3, 0, 32'h0, 32'h0, 32'h0, 32'h0,
                 32'h80808080, 32'h7FFF8000, 32'h0003FFFD, 0);
        add_pass(4, 1, 32'h80808080, 32'h80808080, 32'h7F7F7F7F, 32'h7F807F80,
                 32'h80808080, 32'h7FFF7000, 32'h8000FFFF, 0);        // signed extremes
        add_pass(4, 1, 32'h1F2E3D4C, 32'hC4B3A291, 32'h0102FEFD, 32'h80017F00,
                 32'h7F81C03F, 32'h1234ABCD, 32'h80007FFF, 1);
        add_pass(3, 0, 32'h0, 32'h0, 32'h0, 32'h0,
                 32'h3CC35A05, 32'h00FFFF00, 32'h5A5A0000, 1);
        add_pass(2, 1, 32'h0F0E0D0C, 32'hF0F1F2F3, 32'h0, 32'h0,
                 32'h0302FFFE, 32'h7FFF0001, 32'h0, 1);
        repeat (5) @(posedge clk);
        #2 reset = 1'b0;
        errs_before = err_count;
        repeat (3) begin                              // idle outputs after reset
            @(posedge clk);
            #2;
            check_idle("after reset");
        end
        report_test(0, errs_before);
        foreach (pass_q[i]) begin
            if (!timed_out) begin
                errs_before = err_count;
                run_pass(pass_q[i], i + 1);
                report_test(i + 1, errs_before);
            end
        end
        $display("tests ok %0d, failed %0d", tests_ok, tests_bad);
        if (tests_bad == 0 && !timed_out) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

// File: design/conv_unit.sv
`timescale 1ns/100ps

module conv_unit (
    input  logic                              clk,
    input  logic                              reset,
    input  logic [conv_cfg_pkg::BUS_W-1:0]    data_in,     // from global buffer
    output logic [conv_cfg_pkg::BUS_W-1:0]    data_out,    // to global buffer
    input  logic                              valid_w,
    input  logic                              valid_if,
    input  logic                              valid_ip,
    output logic                              ready_w,
    output logic                              ready_if,
    output logic                              ready_ip,
    output logic                              valid_op,
    input  logic                              ready_op,
    input  logic [conv_cfg_pkg::ROW_EN_W-1:0] row_en       // active rows, 1..4
);
    import conv_types_pkg::*;

    buf_ctrl_t   ctrl;          // strobes from the FSM
    weight_blk_t weight_blk;    // held weights, reused across passes
    ifmap_vec_t  ifmap_vec;
    psum_vec_t   ipsum_vec;
    psum_vec_t   pe_result;     // reducer output

    //----------------------------------------------------------------------
    // phase control
    //----------------------------------------------------------------------
    conv_ctrl conv_ctrl_inst (
        .clk      (clk),
        .reset    (reset),
        .valid_w  (valid_w),
        .valid_if (valid_if),
        .valid_ip (valid_ip),
        .ready_op (ready_op),
        .row_en   (row_en),
        .ready_w  (ready_w),
        .ready_if (ready_if),
        .ready_ip (ready_ip),
        .valid_op (valid_op),
        .ctrl     (ctrl)
    );

    //----------------------------------------------------------------------
    // operand buffers, one module for three payloads
    //----------------------------------------------------------------------
    operand_buffer #(.payload_t(weight_blk_t)) weight_buf_inst (
        .clk      (clk),
        .reset    (reset),
        .data_in  (data_in),
        .we       (ctrl.weight_we),
        .word_idx (ctrl.word_idx),
        .payload  (weight_blk)
    );

    operand_buffer #(.payload_t(ifmap_vec_t)) ifmap_buf_inst (
        .clk      (clk),
        .reset    (reset),
        .data_in  (data_in),
        .we       (ctrl.ifmap_we),
        .word_idx (ctrl.word_idx),
        .payload  (ifmap_vec)
    );

    operand_buffer #(.payload_t(psum_vec_t)) ipsum_buf_inst (
        .clk      (clk),
        .reset    (reset),
        .data_in  (data_in),
        .we       (ctrl.ipsum_we),
        .word_idx (ctrl.word_idx),
        .payload  (ipsum_vec)
    );

    //----------------------------------------------------------------------
    // compute and output
    //----------------------------------------------------------------------
    pe_array pe_array_inst (
        .clk     (clk),
        .reset   (reset),
        .weights (weight_blk),
        .ifmap   (ifmap_vec),
        .ipsum   (ipsum_vec),
        .start   (ctrl.pe_start),
        .result  (pe_result)
    );

    opsum_buffer opsum_buf_inst (
        .clk      (clk),
        .reset    (reset),
        .store    (ctrl.opsum_store),
        .row_en   (row_en),
        .result   (pe_result),
        .word_idx (ctrl.word_idx),
        .out_en   (valid_op),       // OPSUM_OUT decode
        .data_out (data_out)
    );

endmodule

// File: design/conv_ctrl.sv
`timescale 1ns/100ps

module conv_ctrl (
    input  logic                              clk,
    input  logic                              reset,
    input  logic                              valid_w,
    input  logic                              valid_if,
    input  logic                              valid_ip,
    input  logic                              ready_op,
    input  logic [conv_cfg_pkg::ROW_EN_W-1:0] row_en,
    output logic                              ready_w,
    output logic                              ready_if,
    output logic                              ready_ip,
    output logic                              valid_op,
    output conv_types_pkg::buf_ctrl_t         ctrl
);
    import conv_cfg_pkg::*;
    import conv_types_pkg::*;

    localparam logic [CNT_W-1:0] COMPUTE_LAST = CNT_W'(PE_LATENCY - 1);

    conv_state_t       cs, ns;
    logic [CNT_W-1:0]  cnt;           // handshakes or COMPUTE cycles so far
    logic [ROW_EN_W:0] psum_words;    // ceil(row_en/2)
    logic [CNT_W-1:0]  weight_last;
    logic [CNT_W-1:0]  psum_last;
    logic              hs_w, hs_if, hs_ip, hs_op;
    logic              phase_done;    // last word / cycle of this phase

    //----------------------------------------------------------------------
    // handshake decode, each ready/valid high only in its own phase
    //----------------------------------------------------------------------
    assign ready_w  = (cs == WEIGHT_LOAD);
    assign ready_if = (cs == IFMAP_LOAD);
    assign ready_ip = (cs == IPSUM_LOAD);
    assign valid_op = (cs == OPSUM_OUT);

    assign hs_w  = valid_w  & ready_w;
    assign hs_if = valid_if & ready_if;
    assign hs_ip = valid_ip & ready_ip;
    assign hs_op = valid_op & ready_op;

    // last word index per phase
    assign weight_last = CNT_W'(row_en - 1'b1);    // one word per row
    assign psum_words  = ({1'b0, row_en} + (ROW_EN_W + 1)'(PSUM_PER_WORD - 1))
                         / (ROW_EN_W + 1)'(PSUM_PER_WORD);
    assign psum_last   = CNT_W'(psum_words - 1'b1);

    always_comb begin
        case (cs)
            WEIGHT_LOAD: phase_done = hs_w && (cnt == weight_last);
            IFMAP_LOAD:  phase_done = hs_if && (cnt == '0);     // single word
            IPSUM_LOAD:  phase_done = hs_ip && (cnt == psum_last);
            COMPUTE:     phase_done = (cnt == COMPUTE_LAST);    // no handshake
            OPSUM_OUT:   phase_done = hs_op && (cnt == psum_last);
            default:     phase_done = 1'b0;
        endcase
    end

    //----------------------------------------------------------------------
    // phase FSM
    //----------------------------------------------------------------------
    always_comb begin
        ns = cs;                                        // hold by default
        case (cs)
            IDLE: begin
                if (valid_w) begin                      // new weights first
                    ns = WEIGHT_LOAD;
                end else if (valid_if) begin            // reuse stored weights
                    ns = IFMAP_LOAD;
                end
            end
            WEIGHT_LOAD: begin
                if (phase_done) begin
                    ns = IFMAP_LOAD;                    // continue into ifmap
                end
            end
            IFMAP_LOAD: begin
                if (phase_done) begin
                    ns = IPSUM_LOAD;
                end
            end
            IPSUM_LOAD: begin
                if (phase_done) begin
                    ns = COMPUTE;
                end
            end
            COMPUTE: begin
                if (phase_done) begin
                    ns = OPSUM_OUT;
                end
            end
            OPSUM_OUT: begin
                if (phase_done) begin
                    ns = IDLE;                          // pass complete
                end
            end
            default: ns = IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            cs <= IDLE;
        end else begin
            cs <= ns;
        end
    end

    // shared counter, stalls simply hold it
    always_ff @(posedge clk) begin
        if (reset) begin
            cnt <= '0;
        end else if (phase_done) begin
            cnt <= '0;
        end else if (hs_w || hs_if || hs_ip || hs_op || (cs == COMPUTE)) begin
            cnt <= cnt + 1'b1;
        end
    end

    //----------------------------------------------------------------------
    // datapath strobes
    //----------------------------------------------------------------------
    always_comb begin
        ctrl.weight_we   = hs_w;
        ctrl.ifmap_we    = hs_if;
        ctrl.ipsum_we    = hs_ip;
        ctrl.word_idx    = cnt;                         // also opsum read index
        ctrl.pe_start    = (cs == COMPUTE) && (cnt == '0);
        ctrl.opsum_store = (cs == COMPUTE) && (cnt == COMPUTE_LAST);
    end

endmodule

// File: design/opsum_buffer.sv
`timescale 1ns/100ps

module opsum_buffer (
    input  logic                              clk,
    input  logic                              reset,
    input  logic                              store,      // last COMPUTE cycle
    input  logic [conv_cfg_pkg::ROW_EN_W-1:0] row_en,
    input  conv_types_pkg::psum_vec_t         result,
    input  logic [conv_cfg_pkg::CNT_W-1:0]    word_idx,   // opsum words sent so far
    input  logic                              out_en,     // OPSUM_OUT decode
    output logic [conv_cfg_pkg::BUS_W-1:0]    data_out
);
    import conv_cfg_pkg::*;
    import conv_types_pkg::*;

    psum_vec_t                        masked;     // inactive rows zeroed
    psum_vec_t                        opsum_q;
    logic [PSUM_WORDS-1:0][BUS_W-1:0] word_view;  // two psums per word

    //----------------------------------------------------------------------
    // capture
    //----------------------------------------------------------------------
    // rows at or above row_en give zero, so an odd row_en leaves
    // the high half of the last word clear
    always_comb begin
        for (int r = 0; r < ROWS; r++) begin
            masked[r] = (r < int'(row_en)) ? result[r] : '0;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            opsum_q <= '0;
        end else if (store) begin
            opsum_q <= masked;                   // visible next cycle
        end
    end

    //----------------------------------------------------------------------
    // output word select
    //----------------------------------------------------------------------
    assign word_view = opsum_q;
    assign data_out  = out_en ? word_view[word_idx] : '0;   // zero outside OPSUM_OUT

endmodule

// File: design/pe_array.sv
`timescale 1ns/100ps

module pe_array (
    input  logic                        clk,
    input  logic                        reset,
    input  conv_types_pkg::weight_blk_t weights,
    input  conv_types_pkg::ifmap_vec_t  ifmap,
    input  conv_types_pkg::psum_vec_t   ipsum,
    input  logic                        start,    // first COMPUTE cycle
    output conv_types_pkg::psum_vec_t   result
);
    import conv_cfg_pkg::*;
    import conv_types_pkg::*;

    logic signed [PROD_W-1:0] prod_q [ROWS][COLS];   // stage one products
    psum_vec_t                row_sum;              // reduce + ipsum, comb
    psum_vec_t                sum_q;                // stage two register
    logic                     vld_q;                // second valid slot
    logic                     sum_en;

    //----------------------------------------------------------------------
    // stage one, signed 8x8 products for every PE
    //----------------------------------------------------------------------
    // operands sit in the buffers at least one cycle before COMPUTE,
    // so this stage has settled by the time start arrives
    always_ff @(posedge clk) begin
        for (int r = 0; r < ROWS; r++) begin
            for (int c = 0; c < COLS; c++) begin
                prod_q[r][c] <= weights[r][c] * ifmap[c];   // sign kept
            end
        end
    end

    //----------------------------------------------------------------------
    // stage two, row reduction plus ipsum
    //----------------------------------------------------------------------
    always_comb begin
        for (int r = 0; r < ROWS; r++) begin
            row_sum[r] = ipsum[r];                          // start from ipsum
            for (int c = 0; c < COLS; c++) begin
                row_sum[r] = row_sum[r] + PSUM_W'(prod_q[r][c]);   // wraps at 16
            end
        end
    end

    // valid pipeline, keeps stage two loading across the COMPUTE window
    always_ff @(posedge clk) begin
        if (reset) begin
            vld_q <= 1'b0;
        end else begin
            vld_q <= start;
        end
    end

    assign sum_en = start | vld_q;

    always_ff @(posedge clk) begin
        if (sum_en) begin
            sum_q <= row_sum;                               // holds after the pass
        end
    end

    assign result = sum_q;

endmodule

// File: design/operand_buffer.sv
`timescale 1ns/100ps

module operand_buffer #(
    parameter type payload_t = logic [conv_cfg_pkg::BUS_W-1:0]
) (
    input  logic                           clk,
    input  logic                           reset,
    input  logic [conv_cfg_pkg::BUS_W-1:0] data_in,
    input  logic                           we,         // already handshake qualified
    input  logic [conv_cfg_pkg::CNT_W-1:0] word_idx,
    output payload_t                       payload
);
    import conv_cfg_pkg::*;

    localparam int N_WORDS = $bits(payload_t) / BUS_W;   // bus words per payload

    logic [N_WORDS-1:0][BUS_W-1:0] words_q;               // word k = bits 32k+

    // write the bus word into its slot, contents kept between passes
    always_ff @(posedge clk) begin
        if (reset) begin
            words_q <= '0;
        end else if (we && (int'(word_idx) < N_WORDS)) begin
            words_q[word_idx] <= data_in;
        end
    end

    // same bits, seen as the payload type
    assign payload = payload_t'(words_q);

endmodule

// File: design/conv_types_pkg.sv
package conv_types_pkg;

    import conv_cfg_pkg::*;

    //----------------------------------------------------------------------
    // controller phases
    //----------------------------------------------------------------------
    typedef enum logic [2:0] {
        IDLE,          // waits for a pending weight or ifmap
        WEIGHT_LOAD,   // row_en weight words
        IFMAP_LOAD,    // one ifmap word
        IPSUM_LOAD,    // ceil(row_en/2) ipsum words
        COMPUTE,       // PE_LATENCY cycles
        OPSUM_OUT      // ceil(row_en/2) opsum words
    } conv_state_t;

    //----------------------------------------------------------------------
    // payloads
    //----------------------------------------------------------------------
    typedef logic signed [DATA_W-1:0] data_t;   // elements keep their sign
    typedef logic signed [PSUM_W-1:0] psum_t;

    // column c sits in byte c of the word
    typedef data_t [COLS-1:0] ifmap_vec_t;
    typedef data_t [COLS-1:0] weight_row_t;

    // row r is bus word r
    typedef weight_row_t [ROWS-1:0] weight_blk_t;

    // word k holds row 2k low, row 2k+1 high
    typedef psum_t [ROWS-1:0] psum_vec_t;

    //----------------------------------------------------------------------
    // controller strobes to the datapath
    //----------------------------------------------------------------------
    typedef struct packed {
        logic             weight_we;    // qualified by valid_w & ready_w
        logic             ifmap_we;     // qualified by valid_if & ready_if
        logic             ipsum_we;     // qualified by valid_ip & ready_ip
        logic [CNT_W-1:0] word_idx;     // words done in this phase
        logic             pe_start;     // first COMPUTE cycle
        logic             opsum_store;  // last COMPUTE cycle
    } buf_ctrl_t;

endpackage

// File: design/conv_cfg_pkg.sv
package conv_cfg_pkg;

    //----------------------------------------------------------------------
    // bus and array geometry
    //----------------------------------------------------------------------
    localparam int BUS_W    = 32;              // data_in / data_out width
    localparam int ROWS     = 4;               // output channels, one per array row
    localparam int COLS     = 4;               // input channels, one per array column

    localparam int DATA_W   = 8;               // signed weight / ifmap value
    localparam int PSUM_W   = 16;              // signed ipsum / opsum value, wraps
    localparam int PROD_W   = 2 * DATA_W;      // full product width, fits a psum

    localparam int PSUM_PER_WORD = 2;          // two psums packed per bus word
    localparam int PSUM_WORDS    = ROWS / PSUM_PER_WORD; // words for all rows

    //----------------------------------------------------------------------
    // timing and control widths
    //----------------------------------------------------------------------
    localparam int PE_LATENCY = 2;             // COMPUTE cycles, product + reduce

    localparam int CNT_W    = 3;               // word counter, max index ROWS-1
    localparam int ROW_EN_W = 3;               // row_en holds 1..ROWS

endpackage
